/* include/sdram_map_config.svh */
// Memory map constants: header length, bank starts, PCM offset and address widths
`ifndef SDRAM_MAP_CONFIG_SVH
`define SDRAM_MAP_CONFIG_SVH

// Loader stream layout, in bytes
`define HEADER_LEN   25'd32        // Header bytes ahead of the game data
`define BA1_START    25'h04_0000   // First byte that goes to bank 1

// SDRAM word addressing
`define BANK_ADDR_W  22

// Sound ROM fills the first 32 kB of bank 1, PCM samples follow
`define PCM_OFFSET   22'h00_4000   // In 16-bit words

// Requester address widths
`define SND_AW       15            // Byte address
`define PCM_AW       17            // Byte address
`define RAM_AW       14            // Word address, 32 kB work RAM

`endif

/* design/sdram_map_pkg.sv */
// Shared types: arbiter FSM states and loader bank select
package sdram_map_pkg;

    // Slot FSM, shared by the RAM slot and the ROM arbiter
    typedef enum logic [1:0] {
        idle      = 2'd0,   // Waiting for a requester
        wait_ack  = 2'd1,   // rd/wr held until the bank takes it
        wait_data = 2'd2    // Waiting for rdy
    } arb_state_t;

    // Destination bank of a loader word
    typedef enum logic [1:0] {
        bank_0 = 2'd0,      // Main CPU side
        bank_1 = 2'd1       // Sound ROM and PCM samples
    } bank_sel_t;

endpackage

/* design/sdram_bank_if.sv */
// Interface sdram_bank_if: one SDRAM bank's request bundle with slot and memory modports
`timescale 1ns/1ps

`include "sdram_map_config.svh"

interface sdram_bank_if;
    logic [`BANK_ADDR_W-1:0] addr;   // Word address
    logic                    rd;
    logic                    wr;
    logic [15:0]             wdata;
    logic [1:0]              wmask;  // Active low byte enables
    logic                    ack;    // Request taken
    logic                    rdy;    // One-cycle strobe, rdata valid
    logic [15:0]             rdata;

    // Requester side
    modport slot (
        output addr, rd, wr, wdata, wmask,
        input  ack, rdy, rdata
    );

    // SDRAM controller side
    modport mem (
        input  addr, rd, wr, wdata, wmask,
        output ack, rdy, rdata
    );
endinterface

/* design/rom_download.sv */
// Module rom_download: header byte capture and byte-to-word packing for the loader
`timescale 1ns/1ps

`include "sdram_map_config.svh"

module rom_download (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     downloading,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    output logic [7:0]               game_id,
    output logic                     dec_en,
    output logic                     dec_type,
    output logic                     dwnld_busy,
    output logic [`BANK_ADDR_W-1:0]  prog_addr,
    output logic [15:0]              prog_data,
    output logic [1:0]               prog_mask,
    output sdram_map_pkg::bank_sel_t prog_ba,
    output logic                     prog_we
);
    import sdram_map_pkg::*;

    logic        header;
    logic        byte_wr;
    logic [7:0]  low_byte;   // Even byte waiting for its partner
    logic        wr1;
    logic [24:0] addr1;
    logic [15:0] data1;
    logic        in_ba1;
    logic [24:0] rel_addr;

    assign header  = ioctl_addr < `HEADER_LEN;
    assign byte_wr = downloading && ioctl_wr;

    // Bank decode on the first pipeline stage
    assign in_ba1   = addr1 >= `BA1_START;
    assign rel_addr = in_ba1 ? addr1 - `BA1_START : addr1 - `HEADER_LEN;

    assign prog_mask  = 2'b00;                     // Both lanes always written
    assign dwnld_busy = downloading | wr1 | prog_we;  // Covers the write tail

    // Header fields and the pipeline valid bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            game_id  <= 8'd0;
            dec_en   <= 1'b0;
            dec_type <= 1'b0;
            wr1      <= 1'b0;
            prog_we  <= 1'b0;
        end else begin
            if (byte_wr && header && ioctl_addr[4:0] == 5'h10) begin
                dec_en   <= |ioctl_data[1:0];
                dec_type <= ioctl_data[1];
            end
            if (byte_wr && header && ioctl_addr[4:0] == 5'h18)
                game_id <= ioctl_data;
            wr1     <= byte_wr && !header && ioctl_addr[0];  // Odd byte closes a word
            prog_we <= wr1;
        end
    end

    always_ff @(posedge clk) begin
        if (byte_wr && !ioctl_addr[0])
            low_byte <= ioctl_data;
        if (byte_wr && ioctl_addr[0]) begin
            addr1 <= ioctl_addr;
            data1 <= {ioctl_data, low_byte};   // Even byte in the low lane
        end
        if (wr1) begin
            prog_addr <= rel_addr[`BANK_ADDR_W:1];
            prog_data <= data1;
            prog_ba   <= in_ba1 ? bank_1 : bank_0;
        end
    end

endmodule

/* design/ram_slot.sv */
// Module ram_slot: single read/write slot turning a CPU access into one bank transaction
`timescale 1ns/1ps

`include "sdram_map_config.svh"

module ram_slot (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cs,
    input  logic [`BANK_ADDR_W-1:0] addr,
    input  logic                    rnw,
    input  logic [15:0]             din,
    input  logic [1:0]              dsn,
    output logic [15:0]             dout,
    output logic                    ok,
    sdram_bank_if.slot              bank
);
    import sdram_map_pkg::*;

    arb_state_t              state;
    logic                    served;     // Current cs already answered
    logic [`BANK_ADDR_W-1:0] last_addr;
    logic                    last_rnw;
    logic                    same;
    logic                    start;

    assign same  = served && addr == last_addr && rnw == last_rnw;
    assign start = state == idle && cs && !same;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= idle;
            bank.rd <= 1'b0;
            bank.wr <= 1'b0;
            ok      <= 1'b0;
            served  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    ok <= cs && same;
                    if (!cs) begin
                        served <= 1'b0;
                    end else if (!same) begin
                        served  <= 1'b0;
                        bank.rd <= rnw;
                        bank.wr <= !rnw;
                        state   <= wait_ack;
                    end
                end
                wait_ack: if (bank.ack) begin
                    bank.rd <= 1'b0;
                    bank.wr <= 1'b0;
                    state   <= wait_data;
                end
                wait_data: if (bank.rdy) begin
                    // Answer only if the CPU still wants this access
                    served <= cs;
                    ok     <= cs && addr == last_addr && rnw == last_rnw;
                    state  <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            last_addr   <= addr;
            last_rnw    <= rnw;
            bank.addr   <= addr;
            bank.wdata  <= din;
            bank.wmask  <= dsn;   // Same active low sense
        end
        if (state == wait_data && bank.rdy && last_rnw)
            dout <= bank.rdata;
    end

endmodule

/* design/rom_slots.sv */
// Module rom_slots: two-slot read-only arbiter for sound ROM and PCM with last-word caches
`timescale 1ns/1ps

`include "sdram_map_config.svh"

module rom_slots (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               snd_cs,
    input  logic [`SND_AW-1:0] snd_addr,
    input  logic               pcm_cs,
    input  logic [`PCM_AW-1:0] pcm_addr,
    output logic [7:0]         snd_data,
    output logic               snd_ok,
    output logic [7:0]         pcm_data,
    output logic               pcm_ok,
    sdram_bank_if.slot         bank
);
    import sdram_map_pkg::*;

    // Slot 0 is sound, slot 1 is PCM; sound addresses widened to PCM width
    arb_state_t              state;
    logic [1:0]              cs_in;
    logic [`PCM_AW-1:0]      addr_in   [2];
    logic [`PCM_AW-1:0]      last_seen [2];
    logic [`PCM_AW-2:0]      tag       [2];   // Cached word address
    logic [15:0]             word_q    [2];
    logic [1:0]              valid;
    logic [1:0]              hit;
    logic [1:0]              miss;
    logic [1:0]              fill;
    logic [1:0]              ok_next;
    logic [1:0]              ok_q;
    logic                    served;          // Slot owning the bank
    logic [`PCM_AW-2:0]      req_word;
    logic                    pick;
    logic [`PCM_AW-2:0]      pick_word;
    logic [`BANK_ADDR_W-1:0] pick_addr;

    assign cs_in      = {pcm_cs, snd_cs};
    assign addr_in[0] = {{(`PCM_AW - `SND_AW){1'b0}}, snd_addr};
    assign addr_in[1] = pcm_addr;

    // Sound wins when both miss
    assign pick      = !miss[0];
    assign pick_word = addr_in[pick][`PCM_AW-1:1];
    assign pick_addr = (pick ? `PCM_OFFSET : {`BANK_ADDR_W{1'b0}})
                     + {{(`BANK_ADDR_W - `PCM_AW + 1){1'b0}}, pick_word};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i]     = valid[i] && tag[i] == addr_in[i][`PCM_AW-1:1];
            miss[i]    = cs_in[i] && !hit[i];
            fill[i]    = state == wait_data && bank.rdy && served == 1'(i);
            // Held address only, so a new address always drops ok first
            ok_next[i] = cs_in[i] && addr_in[i] == last_seen[i]
                       && (hit[i] || (fill[i] && req_word == addr_in[i][`PCM_AW-1:1]));
        end
    end

    // Byte lane from the address LSB
    assign snd_data = snd_addr[0] ? word_q[0][15:8] : word_q[0][7:0];
    assign pcm_data = pcm_addr[0] ? word_q[1][15:8] : word_q[1][7:0];
    assign snd_ok   = ok_q[0];
    assign pcm_ok   = ok_q[1];

    // Read-only bank
    assign bank.wr    = 1'b0;
    assign bank.wdata = 16'd0;
    assign bank.wmask = 2'b11;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= idle;
            bank.rd      <= 1'b0;
            served       <= 1'b0;
            valid        <= 2'b00;
            ok_q         <= 2'b00;
            last_seen[0] <= '0;
            last_seen[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                last_seen[i] <= addr_in[i];
                ok_q[i]      <= ok_next[i];
            end
            case (state)
                idle: if (|miss) begin
                    served  <= pick;
                    bank.rd <= 1'b1;
                    state   <= wait_ack;
                end
                wait_ack: if (bank.ack) begin
                    bank.rd <= 1'b0;
                    state   <= wait_data;
                end
                wait_data: if (bank.rdy) begin
                    valid[served] <= 1'b1;
                    state         <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && |miss) begin
            req_word  <= pick_word;
            bank.addr <= pick_addr;
        end
        for (int i = 0; i < 2; i++) begin
            if (fill[i]) begin
                word_q[i] <= bank.rdata;
                tag[i]    <= req_word;
            end
        end
    end

endmodule

/* design/sdram_map.sv */
// Module sdram_map: top level joining the loader, RAM slot and sound ROM bank to plain ports
`timescale 1ns/1ps

`include "sdram_map_config.svh"

module sdram_map (
    input  logic                     clk,
    input  logic                     arst_n,
    // Loader
    input  logic                     downloading,
    input  logic [24:0]              ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    output logic                     dwnld_busy,
    output logic [7:0]               game_id,
    output logic                     dec_en,
    output logic                     dec_type,
    output logic [`BANK_ADDR_W-1:0]  prog_addr,
    output logic [15:0]              prog_data,
    output logic [1:0]               prog_mask,
    output sdram_map_pkg::bank_sel_t prog_ba,
    output logic                     prog_we,
    // Main CPU work RAM
    input  logic                     ram_cs,
    input  logic [`RAM_AW-1:0]       ram_addr,
    input  logic                     ram_rnw,
    input  logic [15:0]              ram_din,
    input  logic [1:0]               ram_dsn,
    output logic [15:0]              ram_dout,
    output logic                     ram_ok,
    // Sound CPU and PCM
    input  logic                     snd_cs,
    input  logic [`SND_AW-1:0]       snd_addr,
    output logic [7:0]               snd_data,
    output logic                     snd_ok,
    input  logic                     pcm_cs,
    input  logic [`PCM_AW-1:0]       pcm_addr,
    output logic [7:0]               pcm_data,
    output logic                     pcm_ok,
    // Bank 0
    output logic [`BANK_ADDR_W-1:0]  ba0_addr,
    output logic                     ba0_rd,
    output logic                     ba0_wr,
    output logic [15:0]              ba0_wdata,
    output logic [1:0]               ba0_wmask,
    input  logic                     ba0_ack,
    input  logic                     ba0_rdy,
    input  logic [15:0]              ba0_rdata,
    // Bank 1
    output logic [`BANK_ADDR_W-1:0]  ba1_addr,
    output logic                     ba1_rd,
    output logic                     ba1_wr,
    output logic [15:0]              ba1_wdata,
    output logic [1:0]               ba1_wmask,
    input  logic                     ba1_ack,
    input  logic                     ba1_rdy,
    input  logic [15:0]              ba1_rdata
);
    sdram_bank_if bank0 ();
    sdram_bank_if bank1 ();

    logic [`BANK_ADDR_W-1:0] ram_bank_addr;

    // Work RAM lives in the upper half of bank 0
    assign ram_bank_addr = {1'b1, {(`BANK_ADDR_W - 1 - `RAM_AW){1'b0}}, ram_addr};

    assign ba0_addr    = bank0.addr;
    assign ba0_rd      = bank0.rd;
    assign ba0_wr      = bank0.wr;
    assign ba0_wdata   = bank0.wdata;
    assign ba0_wmask   = bank0.wmask;
    assign bank0.ack   = ba0_ack;
    assign bank0.rdy   = ba0_rdy;
    assign bank0.rdata = ba0_rdata;

    assign ba1_addr    = bank1.addr;
    assign ba1_rd      = bank1.rd;
    assign ba1_wr      = bank1.wr;
    assign ba1_wdata   = bank1.wdata;
    assign ba1_wmask   = bank1.wmask;
    assign bank1.ack   = ba1_ack;
    assign bank1.rdy   = ba1_rdy;
    assign bank1.rdata = ba1_rdata;

    rom_download u_dwnld (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .game_id     (game_id),
        .dec_en      (dec_en),
        .dec_type    (dec_type),
        .dwnld_busy  (dwnld_busy),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we)
    );

    ram_slot u_bank0 (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (ram_cs),
        .addr   (ram_bank_addr),
        .rnw    (ram_rnw),
        .din    (ram_din),
        .dsn    (ram_dsn),
        .dout   (ram_dout),
        .ok     (ram_ok),
        .bank   (bank0.slot)
    );

    rom_slots u_bank1 (
        .clk      (clk),
        .arst_n   (arst_n),
        .snd_cs   (snd_cs),
        .snd_addr (snd_addr),
        .pcm_cs   (pcm_cs),
        .pcm_addr (pcm_addr),
        .snd_data (snd_data),
        .snd_ok   (snd_ok),
        .pcm_data (pcm_data),
        .pcm_ok   (pcm_ok),
        .bank     (bank1.slot)
    );

endmodule

/* test/sdram_bank_model.sv */
// Module sdram_bank_model: behavioral two-bank SDRAM with fixed ack and data latency
`timescale 1ns/1ps

`include "sdram_map_config.svh"

module sdram_bank_model (
    input  logic                         clk,
    input  logic                         arst_n,
    // Loader writes, taken in the cycle of prog_we
    input  logic                         prog_we,
    input  logic [1:0]                   prog_ba,
    input  logic [`BANK_ADDR_W-1:0]      prog_addr,
    input  logic [15:0]                  prog_data,
    input  logic [1:0]                   prog_mask,
    // Request ports, index is the bank
    input  logic [1:0][`BANK_ADDR_W-1:0] addr,
    input  logic [1:0]                   rd,
    input  logic [1:0]                   wr,
    input  logic [1:0][15:0]             wdata,
    input  logic [1:0][1:0]              wmask,
    output logic [1:0]                   ack,
    output logic [1:0]                   rdy,
    output logic [1:0][15:0]             rdata
);
    logic [15:0]           mem [logic [`BANK_ADDR_W:0]];   // Sparse, keyed by {bank, word}
    logic [2:0]            cnt [2];                        // Cycles left to rdy
    logic [`BANK_ADDR_W:0] key [2];

    // Unwritten words read back a pattern built from every address bit
    function automatic logic [15:0] read_word(input logic [`BANK_ADDR_W:0] k);
        return mem.exists(k) ? mem[k] : k[15:0] ^ 16'(k >> 7);
    endfunction

    // Active low byte enables
    function automatic logic [15:0] merge(input logic [15:0] old_w, input logic [15:0] new_w,
                                          input logic [1:0] mask);
        return {mask[1] ? old_w[15:8] : new_w[15:8], mask[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack    <= 2'b00;
            rdy    <= 2'b00;
            cnt[0] <= 3'd0;
            cnt[1] <= 3'd0;
        end else begin
            if (prog_we)
                mem[{prog_ba[0], prog_addr}] = merge(read_word({prog_ba[0], prog_addr}),
                                                     prog_data, prog_mask);
            for (int b = 0; b < 2; b++) begin
                ack[b] <= 1'b0;
                rdy[b] <= 1'b0;
                if (cnt[b] != 3'd0) begin
                    cnt[b] <= cnt[b] - 3'd1;
                    if (cnt[b] == 3'd1) begin   // 4 cycles after ack
                        rdy[b]   <= 1'b1;
                        rdata[b] <= read_word(key[b]);
                    end
                end else if (rd[b] || wr[b]) begin
                    ack[b] <= 1'b1;
                    cnt[b] <= 3'd4;
                    key[b] <= {1'(b), addr[b]};
                    if (wr[b])
                        mem[{1'(b), addr[b]}] = merge(read_word({1'(b), addr[b]}),
                                                      wdata[b], wmask[b]);
                end
            end
        end
    end

endmodule

/* test/tb_sdram_map.sv */
// Testbench tb_sdram_map: directed loader, ROM slot and RAM slot tests against a bank model
`timescale 1ns/1ps

`include "sdram_map_config.svh"

module tb_sdram_map;
    import sdram_map_pkg::*;

    // The tests take about 1000 cycles
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int SND_BASE = 'h100;   // Loaded sound window in bytes
    localparam int PCM_BASE = 'h200;   // Loaded PCM window in bytes
    localparam int WIN      = 64;
    localparam logic [`BANK_ADDR_W-1:0] RAM_REGION = {1'b1, {(`BANK_ADDR_W - 1){1'b0}}};

    logic                    clk;
    logic                    arst_n;
    logic                    downloading;
    logic [24:0]             ioctl_addr;
    logic [7:0]              ioctl_data;
    logic                    ioctl_wr;
    logic                    dwnld_busy;
    logic [7:0]              game_id;
    logic                    dec_en;
    logic                    dec_type;
    logic [`BANK_ADDR_W-1:0] prog_addr;
    logic [15:0]             prog_data;
    logic [1:0]              prog_mask;
    bank_sel_t               prog_ba;
    logic                    prog_we;
    logic                    ram_cs;
    logic [`RAM_AW-1:0]      ram_addr;
    logic                    ram_rnw;
    logic [15:0]             ram_din;
    logic [1:0]              ram_dsn;
    logic [15:0]             ram_dout;
    logic                    ram_ok;
    logic                    snd_cs;
    logic [`SND_AW-1:0]      snd_addr;
    logic [7:0]              snd_data;
    logic                    snd_ok;
    logic                    pcm_cs;
    logic [`PCM_AW-1:0]      pcm_addr;
    logic [7:0]              pcm_data;
    logic                    pcm_ok;

    // Bank side signals indexed by bank
    wire [1:0][`BANK_ADDR_W-1:0] bk_addr;
    wire [1:0]                   bk_rd;
    wire [1:0]                   bk_wr;
    wire [1:0][15:0]             bk_wdata;
    wire [1:0][1:0]              bk_wmask;
    wire [1:0]                   bk_ack;
    wire [1:0]                   bk_rdy;
    wire [1:0][15:0]             bk_rdata;

    logic [7:0]  ref_mem [int];   // Every byte sent by the loader
    logic [39:0] exp_q [$];       // {bank, word address, data} per loader word
    int          last_rom [2];    // Address held on each ROM slot
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          we_seen = 0;
    int          ba1_reads = 0;

    sdram_map dut0 (
        .*,
        .ba0_addr  (bk_addr[0]),
        .ba0_rd    (bk_rd[0]),
        .ba0_wr    (bk_wr[0]),
        .ba0_wdata (bk_wdata[0]),
        .ba0_wmask (bk_wmask[0]),
        .ba0_ack   (bk_ack[0]),
        .ba0_rdy   (bk_rdy[0]),
        .ba0_rdata (bk_rdata[0]),
        .ba1_addr  (bk_addr[1]),
        .ba1_rd    (bk_rd[1]),
        .ba1_wr    (bk_wr[1]),
        .ba1_wdata (bk_wdata[1]),
        .ba1_wmask (bk_wmask[1]),
        .ba1_ack   (bk_ack[1]),
        .ba1_rdy   (bk_rdy[1]),
        .ba1_rdata (bk_rdata[1])
    );

    sdram_bank_model u_mem (
        .*,
        .addr  (bk_addr),
        .rd    (bk_rd),
        .wr    (bk_wr),
        .wdata (bk_wdata),
        .wmask (bk_wmask),
        .ack   (bk_ack),
        .rdy   (bk_rdy),
        .rdata (bk_rdata)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (bk_rd[1] && bk_ack[1])
            ba1_reads++;   // Accepted bank 1 reads
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (prog_we) begin
            we_seen++;
            check_prog_word();
        end
        if (bk_rd[0] || bk_wr[0])
            check_ram_bank_addr();
    end

    task automatic check_prog_word();
        logic [39:0] exp_w;
        logic [39:0] got_w;
        got_w = {prog_ba, prog_addr, prog_data};
        checks++;
        if (exp_q.size() == 0) begin
            errors++;
            $display("prog_we pulse at %0t with no loader word pending", $time);
        end else begin
            exp_w = exp_q.pop_front();
            if (got_w !== exp_w) begin
                errors++;
                $display("** Error at %0t: prog ba/addr/data %h, expected %h", $time, got_w, exp_w);
            end
        end
        checks++;
        if (prog_mask !== 2'b00) begin
            errors++;
            $display("** Error at %0t: prog_mask %b, expected 00", $time, prog_mask);
        end
    endtask

    task automatic check_ram_bank_addr();
        logic [`BANK_ADDR_W-1:0] expect_a;
        expect_a = RAM_REGION | {{(`BANK_ADDR_W - `RAM_AW){1'b0}}, ram_addr};
        checks++;
        if (bk_addr[0] !== expect_a) begin
            errors++;
            $display("** Error at %0t: bank 0 address %h, expected %h", $time, bk_addr[0], expect_a);
        end
    endtask

    task automatic check_reset_state();
        checks++;
        if ({ram_ok, snd_ok, pcm_ok, bk_rd, bk_wr, prog_we, dec_en, dec_type, game_id} !== '0) begin
            errors++;
            $display("** Error at %0t: outputs not low after reset", $time);
        end
    endtask

    // One loader strobe that queues the expected word on odd data bytes
    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        logic [1:0]  ba;
        logic [24:0] base;
        @(negedge clk);
        ioctl_addr       = a;
        ioctl_data       = d;
        ioctl_wr         = 1'b1;
        ref_mem[int'(a)] = d;
        if (a >= `HEADER_LEN && a[0]) begin
            ba   = (a >= `BA1_START) ? 2'd1 : 2'd0;
            base = (a >= `BA1_START) ? `BA1_START : `HEADER_LEN;
            exp_q.push_back({ba, 22'((a - base) >> 1), d, ref_mem[int'(a) - 1]});
        end
        @(negedge clk);
        checks++;
        if (dwnld_busy !== 1'b1) begin
            errors++;
            $display("** Error at %0t: dwnld_busy %b during download, expected 1",
                     $time, dwnld_busy);
        end
        ioctl_wr = 1'b0;
    endtask

    task automatic load_header(input logic [7:0] b10, input logic [7:0] b18);
        int         we_before;
        logic [7:0] d;
        we_before = we_seen;
        for (int i = 0; i < int'(`HEADER_LEN); i++) begin
            d = (i == 'h10) ? b10 : (i == 'h18) ? b18 : 8'($urandom);
            load_byte(25'(i), d);
        end
        repeat (3) @(negedge clk);   // Past the loader pipeline
        checks++;
        if (game_id !== b18 || dec_en !== (|b10[1:0]) || dec_type !== b10[1]) begin
            errors++;
            $display("** Error at %0t: header %h/%h gave game_id %h dec_en %b dec_type %b",
                     $time, b10, b18, game_id, dec_en, dec_type);
        end
        checks++;
        if (we_seen != we_before) begin
            errors++;
            $display("Header load at %0t produced %0d prog_we pulses", $time, we_seen - we_before);
        end
    endtask

    task automatic load_block(input int start, input int len);
        for (int i = 0; i < len; i++)
            load_byte(25'(start + i), 8'($urandom));
    endtask

    task automatic check_rom_byte(input bit pcm, input int a, input logic [7:0] got);
        int         loader_addr;
        logic [7:0] expect_b;
        // Bank 1 word is the slot word shifted by PCM_OFFSET on the PCM slot
        loader_addr = int'(`BA1_START) + 2 * (a / 2 + (pcm ? int'(`PCM_OFFSET) : 0)) + a % 2;
        expect_b    = ref_mem[loader_addr];
        checks++;
        if (got !== expect_b) begin
            errors++;
            $display("** Error at %0t: %s byte at %h is %h, expected %h",
                     $time, pcm ? "pcm" : "snd", a, got, expect_b);
        end
    endtask

    task automatic rom_read(input bit pcm, input int a);
        @(negedge clk);
        if (pcm) begin
            pcm_cs   = 1'b1;
            pcm_addr = a[`PCM_AW-1:0];
        end else begin
            snd_cs   = 1'b1;
            snd_addr = a[`SND_AW-1:0];
        end
        last_rom[pcm] = a;
        @(negedge clk);
        checks++;
        if ((pcm ? pcm_ok : snd_ok) !== 1'b0) begin
            errors++;
            $display("** Error at %0t: ok still high after address change to %h", $time, a);
        end
        while ((pcm ? pcm_ok : snd_ok) !== 1'b1)
            @(negedge clk);
        check_rom_byte(pcm, a, pcm ? pcm_data : snd_data);
    endtask

    // Miss on a new word and then hit on its other lane
    task automatic test_rom_reads(input bit pcm, input int base);
        int off;
        int reads_before;
        off = int'($urandom % WIN);
        for (int n = 0; n < 6; n++) begin
            off = (off + 2 + int'($urandom % 61)) % WIN;
            rom_read(pcm, base + off);
            reads_before = ba1_reads;
            rom_read(pcm, base + (off ^ 1));
            checks++;
            if (ba1_reads != reads_before) begin
                errors++;
                $display("** Error at %0t: cache hit at %h issued a bank 1 read", $time, off ^ 1);
            end
        end
    endtask

    task automatic test_concurrent();
        int s;
        int p;
        int reads_before;
        for (int n = 0; n < 4; n++) begin
            s = SND_BASE + (last_rom[0] - SND_BASE + 2 + int'($urandom % 61)) % WIN;
            p = PCM_BASE + (last_rom[1] - PCM_BASE + 2 + int'($urandom % 61)) % WIN;
            @(negedge clk);
            snd_cs       = 1'b1;
            snd_addr     = s[`SND_AW-1:0];
            pcm_cs       = 1'b1;
            pcm_addr     = p[`PCM_AW-1:0];
            last_rom[0]  = s;
            last_rom[1]  = p;
            reads_before = ba1_reads;
            @(negedge clk);
            while (!(snd_ok && pcm_ok))
                @(negedge clk);
            check_rom_byte(1'b0, s, snd_data);
            check_rom_byte(1'b1, p, pcm_data);
            checks++;
            if (ba1_reads != reads_before + 2) begin
                errors++;
                $display("** Error at %0t: %0d bank 1 reads for two misses, expected 2",
                         $time, ba1_reads - reads_before);
            end
        end
        @(negedge clk);
        snd_cs = 1'b0;
        pcm_cs = 1'b0;
    endtask

    task automatic ram_access(input bit rnw, input logic [`RAM_AW-1:0] a,
                              input logic [15:0] d, input logic [1:0] dsn);
        @(negedge clk);
        ram_cs   = 1'b1;
        ram_rnw  = rnw;
        ram_addr = a;
        ram_din  = d;
        ram_dsn  = dsn;
        @(negedge clk);
        while (ram_ok !== 1'b1)
            @(negedge clk);
        ram_cs = 1'b0;
        @(negedge clk);
        checks++;
        if (ram_ok !== 1'b0) begin
            errors++;
            $display("** Error at %0t: ram_ok stayed high after cs fell", $time);
        end
    endtask

    function automatic logic [15:0] apply_dsn(input logic [15:0] old_w, input logic [15:0] new_w,
                                              input logic [1:0] dsn);
        return {dsn[1] ? old_w[15:8] : new_w[15:8], dsn[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    // Each dsn pattern over a full write with a read back after every step
    task automatic test_ram();
        logic [`RAM_AW-1:0] a;
        logic [15:0]        d;
        logic [15:0]        expect_w;
        for (int n = 0; n < 4; n++) begin
            a        = `RAM_AW'($urandom);
            expect_w = 16'($urandom);
            ram_access(1'b0, a, expect_w, 2'b00);
            for (int m = 0; m < 4; m++) begin
                d = 16'($urandom);
                ram_access(1'b0, a, d, 2'(m));
                expect_w = apply_dsn(expect_w, d, 2'(m));
                ram_access(1'b1, a, 16'h0000, 2'b11);
                checks++;
                if (ram_dout !== expect_w) begin
                    errors++;
                    $display("** Error at %0t: RAM %h after dsn %b reads %h, expected %h",
                             $time, a, 2'(m), ram_dout, expect_w);
                end
            end
        end
    endtask

    initial begin
        void'($urandom(32'hea11c0dd));
        clk         = 1'b0;
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = 8'h00;
        ioctl_wr    = 1'b0;
        ram_cs      = 1'b0;
        ram_addr    = '0;
        ram_rnw     = 1'b1;
        ram_din     = 16'h0000;
        ram_dsn     = 2'b11;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        pcm_cs      = 1'b0;
        pcm_addr    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_reset_state();

        downloading = 1'b1;
        load_header(8'hfc, 8'h3c);   // Decryption off
        load_header(8'h01, 8'ha5);
        load_header(8'h0e, 8'h7e);
        load_block(int'(`HEADER_LEN), 32);
        load_block(int'(`BA1_START) + SND_BASE, WIN);
        load_block(int'(`BA1_START) + 2 * int'(`PCM_OFFSET) + PCM_BASE, WIN);
        @(negedge clk);
        downloading = 1'b0;
        while (dwnld_busy)
            @(negedge clk);
        checks++;
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d loader words never reached prog_we", exp_q.size());
        end

        test_rom_reads(1'b0, SND_BASE);
        test_rom_reads(1'b1, PCM_BASE);
        test_concurrent();
        test_ram();

        repeat (2) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
design/sdram_map_pkg.sv
design/sdram_bank_if.sv
design/rom_download.sv
design/ram_slot.sv
design/rom_slots.sv
design/sdram_map.sv
test/sdram_bank_model.sv
test/tb_sdram_map.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_sdram_map -f sources.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
